// ==== Bender.yml ====
package:
  name: mini_pipe

sources:
  - mini_pipe_pkg.sv
  - gpr_file.sv
  - if_stage.sv
  - id_decoder.sv
  - id_reg.sv
  - ex_stage.sv
  - mem_arbiter.sv
  - mini_pipe_top.sv
  - target: test
    files:
      - mini_pipe_checker.sv
      - mini_pipe_tb.sv

// ==== ex_stage.sv ====
/*
 * execute stage
 * alu, load/store sequencing, forwarding and gpr writeback
 */
`timescale 1ns/1ps

module ex_stage (
	input  logic                                 clk,
	input  logic                                 reset,
	input  mini_pipe_pkg::id_bundle_t            ex_bundle,
	output logic                                 ex_busy,
	output mini_pipe_pkg::mem_req_t              data_req,
	input  mini_pipe_pkg::mem_rsp_t              data_rsp,
	output mini_pipe_pkg::fwd_t                  fwd,
	output logic                                 wr_en,
	output logic [mini_pipe_pkg::reg_addr_w-1:0] wr_addr,
	output logic [mini_pipe_pkg::word_w-1:0]     wr_data
);
	import mini_pipe_pkg::*;

	logic [word_w-1:0] alu_res;
	logic              is_mem, is_load;
	logic              served_q; // done seen for the held bundle

	always_comb begin
		case (ex_bundle.alu_op)
			alu_add: alu_res = ex_bundle.alu_in_0 + ex_bundle.alu_in_1;
			alu_sub: alu_res = ex_bundle.alu_in_0 - ex_bundle.alu_in_1;
			alu_and: alu_res = ex_bundle.alu_in_0 & ex_bundle.alu_in_1;
			alu_or:  alu_res = ex_bundle.alu_in_0 | ex_bundle.alu_in_1;
			alu_xor: alu_res = ex_bundle.alu_in_0 ^ ex_bundle.alu_in_1;
			default: alu_res = ex_bundle.alu_in_1; // pass
		endcase
	end

	assign is_mem  = ex_bundle.valid && ex_bundle.mem_op != mem_none;
	assign is_load = ex_bundle.valid && ex_bundle.mem_op == mem_load;

	// ------------------------------------------------
	// memory op holds id_reg through its done cycle
	// ------------------------------------------------
	assign ex_busy = is_mem && !served_q;

	assign data_req.valid = ex_busy;
	assign data_req.write = ex_bundle.mem_op == mem_store;
	assign data_req.addr  = alu_res[addr_w-1:0]; // base + imm
	assign data_req.wdata = ex_bundle.mem_wr_data;

	// done only arrives while busy, the bundle leaves the cycle after
	always_ff @(posedge clk) begin
		if (reset)
			served_q <= 1'b0;
		else
			served_q <= data_rsp.done;
	end

	// writeback, alu in its own cycle, load on done
	always_comb begin
		if (is_load)
			wr_en = data_rsp.done && ex_bundle.gpr_we;
		else
			wr_en = ex_bundle.valid && !is_mem && ex_bundle.gpr_we;
	end

	assign wr_addr = ex_bundle.dst_addr;
	assign wr_data = is_load ? data_rsp.rdata : alu_res;

	assign fwd.valid = wr_en; // same value the gpr gets at the edge
	assign fwd.addr  = wr_addr;
	assign fwd.data  = wr_data;

endmodule

// ==== gpr_file.sv ====
/*
 * 32 x 32 general purpose register file
 * two async read ports, one write port, r0 hardwired to zero
 */
`timescale 1ns/1ps

module gpr_file (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [mini_pipe_pkg::reg_addr_w-1:0] rd_addr_0,
	output logic [mini_pipe_pkg::word_w-1:0]     rd_data_0,
	input  logic [mini_pipe_pkg::reg_addr_w-1:0] rd_addr_1,
	output logic [mini_pipe_pkg::word_w-1:0]     rd_data_1,
	input  logic                                 wr_en,
	input  logic [mini_pipe_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [mini_pipe_pkg::word_w-1:0]     wr_data
);
	import mini_pipe_pkg::*;

	logic [word_w-1:0] regs [2**reg_addr_w];

	// r0 forced to zero on the read side as well
	assign rd_data_0 = (rd_addr_0 == '0) ? '0 : regs[rd_addr_0];
	assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**reg_addr_w; i++)
				regs[i] <= '0; // whole file cleared
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data; // r0 writes dropped
		end
	end

endmodule

// ==== id_decoder.sv ====
/*
 * instruction decode
 * r/i view select, operand mux, alu forwarding, load-use bubble
 */
`timescale 1ns/1ps

module id_decoder (
	input  mini_pipe_pkg::instr_t                instr,
	input  logic                                 instr_valid,
	input  mini_pipe_pkg::id_bundle_t            ex_bundle,
	input  logic                                 ex_busy,
	input  mini_pipe_pkg::fwd_t                  fwd,
	output logic [mini_pipe_pkg::reg_addr_w-1:0] rd_addr_0,
	output logic [mini_pipe_pkg::reg_addr_w-1:0] rd_addr_1,
	input  logic [mini_pipe_pkg::word_w-1:0]     rd_data_0,
	input  logic [mini_pipe_pkg::word_w-1:0]     rd_data_1,
	output mini_pipe_pkg::id_bundle_t            next_bundle,
	output logic                                 flush,
	output logic                                 stall_if
);
	import mini_pipe_pkg::*;

	opcode_t           opcode;
	logic              is_r, is_imm, uses_0, uses_1, load_use;
	logic [word_w-1:0] op_0, op_1, imm_ext;

	// opcode sits at the same bits in both views
	assign opcode = instr.r_fmt.opcode;
	assign is_r   = opcode inside {op_add, op_sub, op_and, op_or, op_xor};
	assign is_imm = opcode inside {op_addi, op_ld, op_st};
	assign uses_0 = is_r || is_imm;
	assign uses_1 = is_r || (opcode == op_st); // st reads its data reg

	assign rd_addr_0 = instr.r_fmt.rs0;
	assign rd_addr_1 = (opcode == op_st) ? instr.i_fmt.rd : instr.r_fmt.rs1;
	assign imm_ext   = {{(word_w-imm_w){instr.i_fmt.imm[imm_w-1]}}, instr.i_fmt.imm};

	// ------------------------------------------------
	// forwarding from this cycle's execute result
	// ------------------------------------------------
	assign op_0 = (fwd.valid && fwd.addr == rd_addr_0 && rd_addr_0 != '0) ? fwd.data : rd_data_0;
	assign op_1 = (fwd.valid && fwd.addr == rd_addr_1 && rd_addr_1 != '0) ? fwd.data : rd_data_1;

	// load in execute feeding a source here
	assign load_use = instr_valid && ex_bundle.valid && ex_bundle.mem_op == mem_load
		&& ex_bundle.gpr_we && ex_bundle.dst_addr != '0
		&& ((uses_0 && ex_bundle.dst_addr == rd_addr_0)
		 || (uses_1 && ex_bundle.dst_addr == rd_addr_1));

	assign flush    = load_use && !ex_busy; // bubble only when id_reg can move
	assign stall_if = load_use || ex_busy;

	always_comb begin
		next_bundle             = id_bubble;
		next_bundle.valid       = instr_valid;
		next_bundle.alu_in_0    = op_0;
		next_bundle.alu_in_1    = is_imm ? imm_ext : op_1;
		next_bundle.mem_wr_data = op_1;
		next_bundle.dst_addr    = instr.i_fmt.rd;
		next_bundle.gpr_we      = is_r || opcode == op_addi || opcode == op_ld;
		case (opcode)
			op_add, op_addi, op_ld, op_st: next_bundle.alu_op = alu_add; // sum is the address
			op_sub:  next_bundle.alu_op = alu_sub;
			op_and:  next_bundle.alu_op = alu_and;
			op_or:   next_bundle.alu_op = alu_or;
			op_xor:  next_bundle.alu_op = alu_xor;
			default: next_bundle.alu_op = alu_pass; // nop and unknown
		endcase
		if (opcode == op_ld)
			next_bundle.mem_op = mem_load;
		else if (opcode == op_st)
			next_bundle.mem_op = mem_store;
	end

endmodule

// ==== id_reg.sv ====
/*
 * decode to execute pipeline register
 * holds under stall, loads a bubble on flush and reset
 */
`timescale 1ns/1ps

module id_reg (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      stall,       // execute busy
	input  logic                      flush,       // load-use bubble
	input  mini_pipe_pkg::id_bundle_t next_bundle,
	output mini_pipe_pkg::id_bundle_t ex_bundle
);
	import mini_pipe_pkg::*;

	id_bundle_t bundle_q;

	assign ex_bundle = bundle_q;

	// ------------------------------------------------
	// stall has priority, decode only flushes when free
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			bundle_q <= id_bubble;
		end else if (!stall) begin
			if (flush)
				bundle_q <= id_bubble; // valid low, no side effects
			else
				bundle_q <= next_bundle;
		end
	end

endmodule

// ==== if_stage.sv ====
/*
 * fetch stage
 * pc, instruction holding register and fetch request to the arbiter
 */
`timescale 1ns/1ps

module if_stage (
	input  logic                            clk,
	input  logic                            reset,
	output mini_pipe_pkg::mem_req_t         fetch_req,
	input  mini_pipe_pkg::mem_rsp_t         fetch_rsp,
	input  logic                            stall_if,
	output mini_pipe_pkg::instr_t           instr,
	output logic                            instr_valid
);
	import mini_pipe_pkg::*;

	logic [addr_w-1:0] pc_q;
	instr_t            instr_q;     // held word for decode
	logic              instr_valid_q;

	// ask while the slot is empty or decode takes the word this cycle
	// slot stays empty after that, so valid stays put until done
	assign fetch_req.valid = !instr_valid_q || !stall_if;
	assign fetch_req.write = 1'b0;
	assign fetch_req.addr  = pc_q;
	assign fetch_req.wdata = '0;

	assign instr       = instr_q;
	assign instr_valid = instr_valid_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q          <= '0;
			instr_valid_q <= 1'b0;
		end else if (fetch_rsp.done) begin
			instr_q       <= fetch_rsp.rdata; // capture and step
			instr_valid_q <= 1'b1;
			pc_q          <= pc_q + 1'b1;
		end else if (instr_valid_q && !stall_if) begin
			instr_valid_q <= 1'b0; // decode took it
		end
	end

endmodule

// ==== mem_arbiter.sv ====
/*
 * fixed priority memory arbiter, data over fetch
 * idle/setup/access fsm driving one apb master port
 */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                    clk,
	input  logic                    reset,
	input  mini_pipe_pkg::mem_req_t fetch_req,
	output mini_pipe_pkg::mem_rsp_t fetch_rsp,
	input  mini_pipe_pkg::mem_req_t data_req,
	output mini_pipe_pkg::mem_rsp_t data_rsp,
	output mini_pipe_pkg::apb_req_t apb_req,
	input  mini_pipe_pkg::apb_rsp_t apb_rsp
);
	import mini_pipe_pkg::*;

	typedef enum logic [1:0] {arb_idle, arb_setup, arb_access} arb_state_t;

	arb_state_t state_q;
	logic       gnt_data_q; // 1 data, 0 fetch
	mem_req_t   sel_req;
	logic       xfer_end;

	assign sel_req  = gnt_data_q ? data_req : fetch_req;
	assign xfer_end = (state_q == arb_access) && apb_rsp.pready;

	// ------------------------------------------------
	// pick at setup, always back to idle after a transfer
	// so a requester's stale valid in its done cycle is ignored
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q    <= arb_idle;
			gnt_data_q <= 1'b0;
		end else begin
			case (state_q)
				arb_idle: begin
					if (data_req.valid) begin
						gnt_data_q <= 1'b1; // data wins
						state_q    <= arb_setup;
					end else if (fetch_req.valid) begin
						gnt_data_q <= 1'b0;
						state_q    <= arb_setup;
					end
				end
				arb_setup:  state_q <= arb_access;
				arb_access: if (apb_rsp.pready) state_q <= arb_idle; // wait states hold here
				default:    state_q <= arb_idle;
			endcase
		end
	end

	assign apb_req.psel    = state_q != arb_idle;
	assign apb_req.penable = state_q == arb_access;
	assign apb_req.pwrite  = sel_req.write;
	assign apb_req.paddr   = sel_req.addr;
	assign apb_req.pwdata  = sel_req.wdata;

	// response only to the granted side
	assign fetch_rsp.done  = xfer_end && !gnt_data_q;
	assign fetch_rsp.rdata = gnt_data_q ? '0 : apb_rsp.prdata;
	assign data_rsp.done   = xfer_end && gnt_data_q;
	assign data_rsp.rdata  = gnt_data_q ? apb_rsp.prdata : '0;

endmodule

// ==== mini_pipe.f ====
mini_pipe_pkg.sv
gpr_file.sv
if_stage.sv
id_decoder.sv
id_reg.sv
ex_stage.sv
mem_arbiter.sv
mini_pipe_top.sv
mini_pipe_checker.sv
mini_pipe_tb.sv

// ==== mini_pipe_checker.sv ====
/*
 * assertions bound into mini_pipe_top
 * apb setup/access order and signal hold under wait states
 * load-use bubble and arbiter grant hold
 */
`timescale 1ns/1ps

module mini_pipe_checker (
	input logic                    clk,
	input logic                    reset,
	input mini_pipe_pkg::apb_req_t apb_req,
	input mini_pipe_pkg::apb_rsp_t apb_rsp,
	input logic                    flush,
	input logic                    ex_valid,  // id_reg output valid
	input logic                    gnt_data   // arbiter grant register
);

	int unsigned fail_cnt = 0; // failure tally

	// ------------------------------------------------
	// apb protocol
	// ------------------------------------------------
	a_psel_reset: assert property (@(posedge clk) reset |=> !apb_req.psel)
		else begin
			$error("psel high after reset");
			fail_cnt++;
		end

	a_penable_after_setup: assert property (@(posedge clk) disable iff (reset)
		$rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
		else begin
			$error("penable rose without a setup cycle");
			fail_cnt++;
		end

	// held from setup through the last wait state
	a_apb_stable: assert property (@(posedge clk) disable iff (reset)
		apb_req.psel && !(apb_req.penable && apb_rsp.pready)
		|=> $stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
		else begin
			$error("apb address or data moved during a transfer");
			fail_cnt++;
		end

	// ------------------------------------------------
	// pipeline control
	// ------------------------------------------------
	a_flush_bubble: assert property (@(posedge clk) disable iff (reset) flush |=> !ex_valid)
		else begin
			$error("no bubble in id_reg after a load-use flush");
			fail_cnt++;
		end

	a_grant_hold: assert property (@(posedge clk) disable iff (reset)
		apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> $stable(gnt_data))
		else begin
			$error("grant changed while a transfer was in progress");
			fail_cnt++;
		end

	a_grant_idle: assert property (@(posedge clk) disable iff (reset)
		$rose(gnt_data) |-> $past(!apb_req.psel))
		else begin
			$error("data request granted during a transfer");
			fail_cnt++;
		end

endmodule

bind mini_pipe_top mini_pipe_checker chk (.clk, .reset, .apb_req, .apb_rsp, .flush,
	.ex_valid (ex_bundle.valid), .gnt_data (u_arb.gnt_data_q));

// ==== mini_pipe_pkg.sv ====
/*
 * shared definitions for the four stage integer core
 * widths, opcodes and the two instruction views
 * decode/execute bundle, forwarding and memory request types
 * apb master request and response structs
 */
package mini_pipe_pkg;

	localparam int word_w     = 32; // data and instruction width
	localparam int reg_addr_w = 5;  // 32 gprs
	localparam int addr_w     = 16; // word address on the memory side
	localparam int imm_w      = 16; // i-type immediate

	typedef enum logic [5:0] {
		op_nop  = 6'd0,
		op_add  = 6'd1,
		op_sub  = 6'd2,
		op_and  = 6'd3,
		op_or   = 6'd4,
		op_xor  = 6'd5,
		op_addi = 6'd6,
		op_ld   = 6'd7,
		op_st   = 6'd8
	} opcode_t;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_pass} alu_op_t;

	typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_op_t;

	// ------------------------------------------------
	// instruction formats, both 32 bits
	// ------------------------------------------------
	typedef struct packed {
		opcode_t                opcode;
		logic [reg_addr_w-1:0]  rd;
		logic [reg_addr_w-1:0]  rs0;
		logic [reg_addr_w-1:0]  rs1;
		logic [10:0]            unused;
	} r_fmt_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [reg_addr_w-1:0]  rd;     // data register for st
		logic [reg_addr_w-1:0]  rs0;
		logic signed [imm_w-1:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_t;

	// decode -> execute bundle, 108 bits
	typedef struct packed {
		logic                  valid;
		alu_op_t               alu_op;
		logic [word_w-1:0]     alu_in_0;
		logic [word_w-1:0]     alu_in_1;    // imm for addi/ld/st
		mem_op_t               mem_op;
		logic [word_w-1:0]     mem_wr_data;
		logic [reg_addr_w-1:0] dst_addr;
		logic                  gpr_we;
	} id_bundle_t;

	localparam id_bundle_t id_bubble = '0; // valid low, no write, no mem op

	typedef struct packed {
		logic                  valid;
		logic [reg_addr_w-1:0] addr;
		logic [word_w-1:0]     data;
	} fwd_t;

	// ------------------------------------------------
	// memory requester side and apb side
	// ------------------------------------------------
	typedef struct packed {
		logic              valid;
		logic              write;
		logic [addr_w-1:0] addr;
		logic [word_w-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic              done;  // one cycle, rdata valid here
		logic [word_w-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [addr_w-1:0] paddr;
		logic [word_w-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic              pready;
		logic [word_w-1:0] prdata;
	} apb_rsp_t;

endpackage

// ==== mini_pipe_tb.sv ====
/*
 * testbench for the four stage core
 * clock, reset, apb memory model with random wait states
 * program builder with an isa-level register model
 * store capture, per-test checks and a cycle limit
 */
`timescale 1ns/1ps

module mini_pipe_tb;
	import mini_pipe_pkg::*;

	localparam int          max_cycles = 3000;     // ~40 instr x 2 xfers x 5 cycles, wide margin
	localparam logic [15:0] end_addr   = 16'h02ff; // closing store lands here

	logic     clk;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     end_seen;
	int       cycles;
	int       bubbles;       // load-use flushes seen
	int       exp_bubbles;   // load then direct use, from the program
	logic [4:0] last_ld;     // dst of the previous instr if it was a load

	logic [31:0] mem [65536];  // memory behind the apb port
	logic [31:0] prog [$];
	logic [31:0] gm [32];      // isa register model
	logic [31:0] mm [int];     // model memory, only written words
	logic [15:0] exp_addr [$], got_addr [$];
	logic [31:0] exp_data [$], got_data [$];
	string       exp_test [$];
	string       tests [$] = '{"fwd_chain", "addi_neg_r0", "load_use", "store_order", "assertions"};
	int          chk_cnt [string];
	int          err_cnt [string];

	mini_pipe_top DUT (.clk, .reset, .apb_req, .apb_rsp);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// whole address folded into the word
	function automatic logic [31:0] fill_word(logic [15:0] a);
		return {a ^ 16'hc3a5, ~a};
	endfunction

	function automatic logic [31:0] model_rd(logic [15:0] a);
		return mm.exists(a) ? mm[a] : fill_word(a);
	endfunction

	// ------------------------------------------------
	// program builder, each call also steps the model
	// ------------------------------------------------
	task automatic emit_r(opcode_t op, logic [4:0] rd, logic [4:0] rs0, logic [4:0] rs1);
		logic [31:0] res;
		case (op)
			op_add:  res = gm[rs0] + gm[rs1];
			op_sub:  res = gm[rs0] - gm[rs1];
			op_and:  res = gm[rs0] & gm[rs1];
			op_or:   res = gm[rs0] | gm[rs1];
			default: res = gm[rs0] ^ gm[rs1];
		endcase
		prog.push_back({op, rd, rs0, rs1, 11'b0});
		if (last_ld != 0 && (rs0 == last_ld || rs1 == last_ld))
			exp_bubbles++; // source loaded by the instr just before
		last_ld = 5'd0;
		if (rd != 0)
			gm[rd] = res; // r0 stays zero
	endtask

	task automatic emit_i(opcode_t op, logic [4:0] rd, logic [4:0] rs0, logic [15:0] imm,
			string tname);
		logic [31:0] sum;
		sum = gm[rs0] + {{16{imm[15]}}, imm}; // sign-extended imm
		prog.push_back({op, rd, rs0, imm});
		if (last_ld != 0 && (rs0 == last_ld || (op == op_st && rd == last_ld)))
			exp_bubbles++;
		last_ld = (op == op_ld) ? rd : 5'd0;
		if (op == op_addi && rd != 0)
			gm[rd] = sum;
		else if (op == op_ld && rd != 0)
			gm[rd] = model_rd(sum[15:0]);
		else if (op == op_st) begin
			mm[sum[15:0]] = gm[rd]; // st data reg sits in rd
			exp_addr.push_back(sum[15:0]);
			exp_data.push_back(gm[rd]);
			exp_test.push_back(tname);
		end
	endtask

	task automatic build_program();
		// dependent alu chain, each one feeds the next
		emit_i(op_addi, 1, 0, 16'd23, "");
		emit_i(op_addi, 2, 0, 16'h1234, "");
		emit_r(op_add, 3, 1, 2);
		emit_r(op_sub, 4, 3, 1);
		emit_r(op_and, 5, 4, 3);
		emit_r(op_or,  6, 5, 2);
		emit_r(op_xor, 7, 6, 4);
		for (int r = 3; r <= 7; r++)
			emit_i(op_st, r[4:0], 0, 16'h01fd + r[15:0], "fwd_chain"); // 0x200..0x204
		emit_i(op_addi, 8, 1, 16'hff9c, "");   // -100
		emit_i(op_addi, 0, 1, 16'd55, "");     // dropped
		emit_i(op_st, 8, 0, 16'h0205, "addi_neg_r0");
		emit_i(op_st, 0, 0, 16'h0206, "addi_neg_r0");
		// loads used in the very next slot
		emit_i(op_ld, 9, 0, 16'h0300, "");
		emit_r(op_add, 10, 9, 1);
		emit_i(op_ld, 11, 2, 16'hefcc, "");    // 0x1234 - 0x1034, reads back r3
		emit_r(op_xor, 12, 11, 9);
		emit_i(op_st, 10, 0, 16'h0207, "load_use");
		emit_i(op_st, 12, 0, 16'h0208, "load_use");
		emit_i(op_st, 3, 1, end_addr - 16'd23, "store_order"); // closing store
		repeat (4)
			prog.push_back(32'h0); // nop padding past the end
	endtask

	task automatic check_word(string tname, string what, logic [31:0] exp, logic [31:0] act);
		chk_cnt[tname]++;
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s expected %h actual %h", tname, what, exp, act);
			err_cnt[tname]++;
		end
	endtask

	// ------------------------------------------------
	// apb memory, inputs change on the falling edge
	// ------------------------------------------------
	initial begin
		int wait_left;
		void'($urandom(65));
		apb_rsp   = '0;
		wait_left = 0;
		forever begin
			@(negedge clk);
			apb_rsp.pready = 1'b0;
			if (!reset && apb_req.psel && !apb_req.penable) begin
				wait_left = $urandom % 4; // 0..3 wait states
			end else if (!reset && apb_req.psel && apb_req.penable) begin
				if (wait_left == 0) begin
					apb_rsp.pready = 1'b1; // transfer ends next edge
					if (apb_req.pwrite) begin
						mem[apb_req.paddr] = apb_req.pwdata;
						got_addr.push_back(apb_req.paddr);
						got_data.push_back(apb_req.pwdata);
						if (apb_req.paddr == end_addr)
							end_seen = 1'b1;
					end else begin
						apb_rsp.prdata = mem[apb_req.paddr];
					end
				end else begin
					wait_left--;
				end
			end
		end
	end

	// bubbles counted mid-cycle where flush is settled
	always @(negedge clk) begin
		if (!reset && DUT.flush)
			bubbles++;
	end

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, closing store never seen", cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		int total_chk;
		int total_err;
		reset       = 1'b1;
		end_seen    = 1'b0;
		bubbles     = 0;
		exp_bubbles = 0;
		last_ld     = 5'd0;
		total_chk   = 0;
		total_err   = 0;
		for (int r = 0; r < 32; r++)
			gm[r] = '0;
		foreach (tests[t]) begin
			chk_cnt[tests[t]] = 0;
			err_cnt[tests[t]] = 0;
		end
		for (int a = 0; a < 65536; a++)
			mem[a] = fill_word(a[15:0]);
		build_program();
		foreach (prog[i])
			mem[i] = prog[i];
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		wait (end_seen);
		repeat (2) @(posedge clk); // let the checker see the last cycles
		foreach (exp_addr[i]) begin
			if (i < got_addr.size()) begin
				check_word("store_order", $sformatf("store %0d addr", i), exp_addr[i], got_addr[i]);
				check_word(exp_test[i], $sformatf("store %0d data", i), exp_data[i], got_data[i]);
			end
		end
		check_word("store_order", "store count", exp_addr.size(), got_addr.size());
		check_word("load_use", "bubble count", exp_bubbles, bubbles);
		check_word("assertions", "checker failures", 0, DUT.chk.fail_cnt);

		foreach (tests[t]) begin
			$display("test %-12s %0d checks, %0d errors", tests[t], chk_cnt[tests[t]],
				err_cnt[tests[t]]);
			total_chk += chk_cnt[tests[t]];
			total_err += err_cnt[tests[t]];
		end
		$display("%0d tests, %0d checks, %0d errors, %0d cycles", tests.size(), total_chk,
			total_err, cycles);
		if (total_err == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== mini_pipe_top.sv ====
/*
 * core top level
 * fetch, decode, stage register, execute, gpr file and apb arbiter
 */
`timescale 1ns/1ps

module mini_pipe_top (
	input  logic                    clk,
	input  logic                    reset,
	output mini_pipe_pkg::apb_req_t apb_req,
	input  mini_pipe_pkg::apb_rsp_t apb_rsp
);
	import mini_pipe_pkg::*;

	mem_req_t              fetch_req, data_req;
	mem_rsp_t              fetch_rsp, data_rsp;
	instr_t                instr;
	logic                  instr_valid, stall_if, flush, ex_busy;
	id_bundle_t            next_bundle, ex_bundle;
	fwd_t                  fwd;
	logic [reg_addr_w-1:0] rd_addr_0, rd_addr_1, wr_addr;
	logic [word_w-1:0]     rd_data_0, rd_data_1, wr_data;
	logic                  wr_en;

	// ------------------------------------------------
	// pipeline
	// ------------------------------------------------
	if_stage u_if (.clk, .reset, .fetch_req, .fetch_rsp, .stall_if, .instr, .instr_valid);

	id_decoder u_dec (.instr, .instr_valid, .ex_bundle, .ex_busy, .fwd,
		.rd_addr_0, .rd_addr_1, .rd_data_0, .rd_data_1, .next_bundle, .flush, .stall_if);

	id_reg u_id_reg (.clk, .reset, .stall (ex_busy), .flush, .next_bundle, .ex_bundle);

	ex_stage u_ex (.clk, .reset, .ex_bundle, .ex_busy, .data_req, .data_rsp, .fwd,
		.wr_en, .wr_addr, .wr_data);

	gpr_file u_gpr (.clk, .reset, .rd_addr_0, .rd_data_0, .rd_addr_1, .rd_data_1,
		.wr_en, .wr_addr, .wr_data);

	// single memory port out to apb
	mem_arbiter u_arb (.clk, .reset, .fetch_req, .fetch_rsp, .data_req, .data_rsp,
		.apb_req, .apb_rsp);

endmodule
